// ==== bench/fm_regs_tb.sv ====
// Testbench for the FM parameter store with stimulus table, register model, checks and timeout
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_regs_tb;
	import fm_pkg::*;

	logic      clk, rst, wr, a0, csm, overflow_a;
	reg_data_t din;
	logic      busy, zero, keyon, mod_m1, mod_m2, mod_c1, amsen;
	op_t       cur_op;
	ch_t       cur_ch;
	small2_t   rl, ams, ks, dt2;
	small3_t   fb, pms, dt1;
	alg_t      con;
	kc_t       kc;
	kf_t       kf;
	tl_t       tl;
	rate4_t    mul, rrate, d1l;
	rate5_t    arate, rate1, rate2;

	// Modulation edges per algorithm at bit dst*4+src for operator numbers as in op_t
	localparam logic [15:0] alg_edges [8] = '{16'h2140, 16'h2050, 16'h3040, 16'h6100,
		16'h2100, 16'h1110, 16'h0100, 16'h0000};

	reg_addr_t tab_addr [300];
	reg_data_t tab_data [300];
	logic      tab_accept [300];
	logic      tab_stack [300];  // Second data write while busy
	logic      tab_check [300];  // Full revolution compare afterwards
	int        n_tab;

	reg_data_t m_ch [4][8];   // Channel registers by group
	reg_data_t m_op [6][32];  // Operator registers by group and slot
	logic      m_key [32];

	logic [31:0] rng;
	int          val_errors, proto_errors, cycles, limit;
	string       where;

	fm_regs_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic reg_data_t next_rand();
		rng = xorshift(rng);
		return rng[7:0];
	endfunction

	task automatic check_param(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s at %s is %h, expected %h", $time, name, where, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s at %s is %b, expected %b", $time, name, where, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_slot(input slot_t got, input slot_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: slot at %s is %0d, expected %0d", $time, where, got, exp);
			val_errors++;
		end
	endtask

	task automatic add_entry(input reg_addr_t addr, input reg_data_t data,
		input logic accept, input logic stack, input logic check);
		tab_addr[n_tab]   = addr;
		tab_data[n_tab]   = data;
		tab_accept[n_tab] = accept;
		tab_stack[n_tab]  = stack;
		tab_check[n_tab]  = check;
		n_tab++;
	endtask

	// Key-on at 08h, channel groups at 20h-3Fh and operator groups at 40h-FFh
	task automatic model_write(input reg_addr_t addr, input reg_data_t data);
		if (addr == `FM_ADDR_KEYON) begin
			for (int k = 0; k < 4; k++)
				m_key[{k[1:0], data[2:0]}] = data[3 + k];  // Bit 3+k is operator k
		end else if (addr[7:5] == 3'd1) begin
			m_ch[addr[4:3]][addr[2:0]] = data;
		end else if (addr[7:5] >= 3'd2) begin
			m_op[addr[7:5] - 3'd2][addr[4:0]] = data;
		end
	endtask

	task automatic build_table();
		reg_data_t r;
		n_tab = 0;
		// Every register once to fill the model
		for (int g = 0; g < 4; g++)
			for (int c = 0; c < 8; c++)
				add_entry(8'(`FM_ADDR_RL + g * 8 + c), next_rand(), 1, 0, 0);
		for (int g = 0; g < 6; g++)
			for (int s = 0; s < 32; s++)
				add_entry(8'(`FM_ADDR_DT1 + g * 32 + s), next_rand(), 1, 0, g == 5 && s == 31);
		add_entry(8'h00, next_rand(), 0, 0, 0);  // Unmapped
		add_entry(8'h10, next_rand(), 0, 0, 0);
		add_entry(8'h1F, next_rand(), 0, 0, 0);
		add_entry(8'h09, next_rand(), 0, 0, 1);
		add_entry(8'h65, next_rand(), 1, 1, 0);  // TL of M1, channel 5
		add_entry(8'h2B, next_rand(), 1, 1, 0);  // KC of channel 3
		add_entry(8'hFE, next_rand(), 1, 1, 1);  // D1L and RR of C2, channel 6
		add_entry(`FM_ADDR_KEYON, {1'b0, 4'b1111, 3'd2}, 1, 0, 1);
		add_entry(`FM_ADDR_KEYON, {1'b0, 4'b0101, 3'd5}, 1, 0, 1);
		add_entry(`FM_ADDR_KEYON, {1'b0, 4'b1010, 3'd5}, 1, 0, 1);
		add_entry(`FM_ADDR_KEYON, {1'b0, 4'b0000, 3'd2}, 1, 0, 1);
		add_entry(`FM_ADDR_KEYON, {1'b0, 4'b0011, 3'd7}, 1, 0, 1);
		// Algorithms spread over the channels and then reversed
		for (int c = 0; c < 8; c++) begin
			r = next_rand();
			add_entry(8'(`FM_ADDR_RL + c), {r[7:3], 3'(c)}, 1, 0, c == 7);
		end
		for (int c = 0; c < 8; c++) begin
			r = next_rand();
			add_entry(8'(`FM_ADDR_RL + c), {r[7:3], 3'(7 - c)}, 1, 0, c == 7);
		end
		limit = 40 * n_tab + 200;
	endtask

	task automatic check_fields(input slot_t s);
		ch_t         c;
		int          d;
		logic [15:0] edges;
		c = s[2:0];
		d = s[4:3];
		edges = alg_edges[m_ch[0][c][2:0]];
		check_param("rl", rl, m_ch[0][c][7:6]);
		check_param("fb", fb, m_ch[0][c][5:3]);
		check_param("con", con, m_ch[0][c][2:0]);
		check_param("kc", kc, m_ch[1][c][6:0]);
		check_param("kf", kf, m_ch[2][c][7:2]);
		check_param("pms", pms, m_ch[3][c][6:4]);
		check_param("ams", ams, m_ch[3][c][1:0]);
		check_param("dt1", dt1, m_op[0][s][6:4]);
		check_param("mul", mul, m_op[0][s][3:0]);
		check_param("tl", tl, m_op[1][s][6:0]);
		check_param("ks", ks, m_op[2][s][7:6]);
		check_param("arate", arate, m_op[2][s][4:0]);
		check_bit("amsen", amsen, m_op[3][s][7]);
		check_param("rate1", rate1, m_op[3][s][4:0]);
		check_param("dt2", dt2, m_op[4][s][7:6]);
		check_param("rate2", rate2, m_op[4][s][4:0]);
		check_param("d1l", d1l, m_op[5][s][7:4]);
		check_param("rrate", rrate, m_op[5][s][3:0]);
		check_bit("keyon", keyon, m_key[s]);
		check_bit("mod_m1", mod_m1, edges[d * 4]);
		check_bit("mod_m2", mod_m2, edges[d * 4 + 1]);
		check_bit("mod_c1", mod_c1, edges[d * 4 + 2]);
	endtask

	task automatic check_revolution();
		slot_t first, s;
		repeat (32) @(negedge clk);  // Written values come round
		for (int i = 0; i < 32; i++) begin
			@(negedge clk);
			s = {cur_op, cur_ch};
			if (i == 0)
				first = s;
			where = $sformatf("slot %0d", s);
			check_slot(s, first + 5'(i));
			check_bit("zero", zero, s == '0);
			check_fields(s);
		end
	endtask

	task automatic apply_entry(input int i);
		int n;
		@(posedge clk);
		wr  <= 1'b1;
		a0  <= 1'b0;
		din <= tab_addr[i];  // Address phase
		@(posedge clk);
		a0  <= 1'b1;
		din <= tab_data[i];
		@(posedge clk);
		wr <= 1'b0;
		@(negedge clk);
		if (!tab_accept[i]) begin
			n = 0;
			repeat (3) begin
				n += busy;
				@(negedge clk);
			end
			if (n != 0) begin
				$display("Busy rose after a write to unmapped address %h", tab_addr[i]);
				proto_errors++;
			end
		end else if (!busy) begin
			$display("Busy did not rise after the data write to address %h", tab_addr[i]);
			proto_errors++;
		end else begin
			n = 0;
			if (tab_stack[i]) begin
				@(posedge clk);
				wr  <= 1'b1;
				din <= ~tab_data[i];  // Must be dropped
				@(posedge clk);
				wr <= 1'b0;
				@(negedge clk);
				n = 2;  // Cycles spent on the dropped write
			end
			while (busy && n < 33) begin
				@(negedge clk);
				n++;
			end
			if (busy) begin
				$display("Busy stayed high too long after the write to address %h", tab_addr[i]);
				proto_errors++;
			end
			model_write(tab_addr[i], tab_data[i]);
		end
		if (tab_check[i])
			check_revolution();
	endtask

	task automatic check_reset();
		@(posedge clk);
		@(negedge clk);
		where = "reset";
		check_bit("busy", busy, 1'b0);
		check_bit("keyon", keyon, 1'b0);
		check_bit("zero", zero, 1'b0);
		check_slot({cur_op, cur_ch}, '0);
		@(posedge clk);
		rst <= 1'b0;
		for (int k = 0; k < 40; k++) begin
			@(negedge clk);
			where = $sformatf("cycle %0d after reset", k);
			check_slot({cur_op, cur_ch}, 5'(k));
			if (k > 0)
				check_bit("zero", zero, k % 32 == 0);
			check_bit("busy", busy, 1'b0);
			check_bit("keyon", keyon, 1'b0);
		end
	endtask

	task automatic timer_keyon(input logic csm_on);
		slot_t s;
		@(posedge clk);
		csm        <= csm_on;
		overflow_a <= 1'b1;
		@(posedge clk);
		overflow_a <= 1'b0;
		for (int i = 0; i < 64; i++) begin
			@(negedge clk);
			s = {cur_op, cur_ch};
			where = $sformatf("timer cycle %0d, slot %0d", i, s);
			check_bit("keyon", keyon, (csm_on && i < 32) ? 1'b1 : m_key[s]);
		end
		@(posedge clk);
		csm <= 1'b0;
	endtask

	// Run limit from the table length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout, the run went past its limit of %0d cycles", limit);
			$display("Errors: %0d value, %0d other", val_errors, proto_errors + 1);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		rst        <= 1'b1;
		wr         <= 1'b0;
		a0         <= 1'b0;
		din        <= '0;
		csm        <= 1'b0;
		overflow_a <= 1'b0;
		val_errors   = 0;
		proto_errors = 0;
		cycles       = 0;
		rng          = 32'd80196;
		for (int s = 0; s < 32; s++)
			m_key[s] = 1'b0;
		build_table();
		check_reset();
		for (int i = 0; i < n_tab; i++)
			apply_entry(i);
		timer_keyon(1'b1);
		timer_keyon(1'b0);  // Pulse ignored without csm
		$display("Errors: %0d value, %0d other", val_errors, proto_errors);
		if (val_errors == 0 && proto_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== include/fm_defs.svh ====
// Slot and channel counts, register address map and group decode masks
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

`define FM_SLOTS    32  // Four operators times eight channels
`define FM_CHANNELS 8

// Key-on register takes the operator mask and channel as data
`define FM_ADDR_KEYON 8'h08

// Channel groups select the channel with address bits 2:0
`define FM_ADDR_RL  8'h20  // RL, FB, CON
`define FM_ADDR_KC  8'h28
`define FM_ADDR_KF  8'h30
`define FM_ADDR_PMS 8'h38  // PMS, AMS

// Operator groups select the operator with bits 4:3 and the channel with bits 2:0
`define FM_ADDR_DT1   8'h40  // DT1, MUL
`define FM_ADDR_TL    8'h60
`define FM_ADDR_KS    8'h80  // KS, AR
`define FM_ADDR_AMSEN 8'hA0  // AMSEN, D1R
`define FM_ADDR_DT2   8'hC0  // DT2, D2R
`define FM_ADDR_D1L   8'hE0  // D1L, RR

`define FM_CH_GRP_MASK 8'hF8  // Strips the channel bits
`define FM_OP_GRP_MASK 8'hE0  // Strips operator and channel bits

`endif

// ==== list.f ====
+incdir+include
logic/fm_pkg.sv
logic/fm_write_decode.sv
logic/fm_reg_file.sv
logic/fm_keyon.sv
logic/fm_algo_route.sv
logic/fm_regs_top.sv
bench/fm_regs_tb.sv

// ==== logic/fm_algo_route.sv ====
// Modulation source flags for the entering operator under each algorithm
`timescale 1ns/1ps

module fm_algo_route (
	input  fm_pkg::alg_t con,
	input  logic         m1_enters,
	input  logic         m2_enters,
	input  logic         c1_enters,
	input  logic         c2_enters,
	output logic         mod_m1,
	output logic         mod_m2,
	output logic         mod_c1
);
	logic m2_by_m1, m2_by_c1;
	logic c1_by_m1;
	logic c2_by_m1, c2_by_m2, c2_by_c1;

	// Edges of the connection graph
	always_comb begin
		{m2_by_m1, m2_by_c1, c1_by_m1, c2_by_m1, c2_by_m2, c2_by_c1} = '0;
		case (con)
			3'd0: {m2_by_c1, c1_by_m1, c2_by_m2} = '1;  // Serial chain
			3'd1: {m2_by_m1, m2_by_c1, c2_by_m2} = '1;
			3'd2: {m2_by_c1, c2_by_m1, c2_by_m2} = '1;
			3'd3: {c1_by_m1, c2_by_c1, c2_by_m2} = '1;
			3'd4: {c1_by_m1, c2_by_m2} = '1;            // Two pairs
			3'd5: {c1_by_m1, m2_by_m1, c2_by_m1} = '1;  // M1 feeds three
			3'd6: c1_by_m1 = 1'b1;
			default: ;                                  // All carriers
		endcase
	end

	// M1 is never modulated by another operator
	assign mod_m1 = (m2_enters && m2_by_m1) || (c1_enters && c1_by_m1) ||
		(c2_enters && c2_by_m1);
	assign mod_m2 = c2_enters && c2_by_m2;
	assign mod_c1 = (m2_enters && m2_by_c1) || (c2_enters && c2_by_c1);

	always_comb begin
		if (!$isunknown({m1_enters, m2_enters, c1_enters, c2_enters}))
			a_one_enters: assert final ($onehot({m1_enters, m2_enters,
				c1_enters, c2_enters}));
	end

endmodule

// ==== logic/fm_keyon.sv ====
// Per-slot key state with register key-on writes and timer key-on window
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_keyon (
	input  logic        clk,
	input  logic        rst,
	input  fm_pkg::op_t cur_op,
	input  fm_pkg::ch_t cur_ch,
	input  logic        keyon_wr,
	input  logic [3:0]  keyon_mask,
	input  fm_pkg::ch_t keyon_ch,
	input  logic        csm,
	input  logic        overflow_a,
	output logic        keyon
);
	import fm_pkg::*;

	slot_t                slot;
	logic [`FM_SLOTS-1:0] key_bits;  // Indexed by {op, ch}
	logic [5:0]           csm_cnt;   // Cycles left in the timer window

	assign slot  = {cur_op, cur_ch};
	assign keyon = (csm_cnt != '0) || key_bits[slot];

	always_ff @(posedge clk) begin
		if (rst) begin
			key_bits <= '0;
		end else if (keyon_wr) begin
			// All four operators of the channel, set or cleared
			for (int k = 0; k < 4; k++)
				key_bits[{op_t'(k), keyon_ch}] <= keyon_mask[k];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			csm_cnt <= '0;
		end else if (csm && overflow_a) begin
			csm_cnt <= 6'(`FM_SLOTS);  // One full revolution
		end else if (csm_cnt != '0) begin
			csm_cnt <= csm_cnt - 6'd1;
		end
	end

endmodule

// ==== logic/fm_pkg.sv ====
// Parameter vector types and the write decoder state encoding
package fm_pkg;

	// Slot index is {op, ch}
	typedef logic [4:0] slot_t;

	// 0 = M1, 1 = M2, 2 = C1, 3 = C2
	typedef logic [1:0] op_t;
	typedef logic [2:0] ch_t;

	// Host bus
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Channel parameters
	typedef logic [2:0] alg_t;   // Connection algorithm
	typedef logic [6:0] kc_t;    // Key code
	typedef logic [5:0] kf_t;    // Key fraction

	// Operator parameters
	typedef logic [6:0] tl_t;    // Total level
	typedef logic [4:0] rate5_t; // AR, D1R, D2R
	typedef logic [3:0] rate4_t; // RR, D1L, MUL

	// Short fields shared by several registers
	typedef logic [2:0] small3_t; // DT1, FB, PMS
	typedef logic [1:0] small2_t; // RL, AMS, KS, DT2

	typedef enum logic {
		DEC_IDLE,
		DEC_PENDING
	} dec_state_t;

endpackage

// ==== logic/fm_reg_file.sv ====
// Slot sequencer with operator and channel parameter memories and write matching
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_reg_file (
	input  logic              clk,
	input  logic              rst,
	input  fm_pkg::reg_data_t d_in,
	input  fm_pkg::op_t       op,
	input  fm_pkg::ch_t       ch,
	input  logic              up_rl,
	input  logic              up_kc,
	input  logic              up_kf,
	input  logic              up_pms,
	input  logic              up_dt1,
	input  logic              up_tl,
	input  logic              up_ks,
	input  logic              up_amsen,
	input  logic              up_dt2,
	input  logic              up_d1l,
	input  logic              up_keyon,
	output logic              busy,
	output fm_pkg::op_t       cur_op,
	output fm_pkg::ch_t       cur_ch,
	output logic              zero,
	output fm_pkg::alg_t      con,
	output logic              m1_enters,
	output logic              m2_enters,
	output logic              c1_enters,
	output logic              c2_enters,
	output logic              keyon_wr,
	output logic [3:0]        keyon_mask,
	output fm_pkg::ch_t       keyon_ch,
	output fm_pkg::small2_t   rl,
	output fm_pkg::small3_t   fb,
	output fm_pkg::kc_t       kc,
	output fm_pkg::kf_t       kf,
	output fm_pkg::small3_t   pms,
	output fm_pkg::small2_t   ams,
	output fm_pkg::small3_t   dt1,
	output fm_pkg::rate4_t    mul,
	output fm_pkg::tl_t       tl,
	output fm_pkg::small2_t   ks,
	output fm_pkg::rate5_t    arate,
	output fm_pkg::rate5_t    rate1,
	output fm_pkg::rate5_t    rate2,
	output fm_pkg::rate4_t    rrate,
	output fm_pkg::small2_t   dt2,
	output fm_pkg::rate4_t    d1l,
	output logic              amsen
);
	import fm_pkg::*;

	slot_t cur, nxt, rd_slot, target;
	logic  up_op, up_ch, up_any;
	logic  op_wr, ch_wr, done;

	logic [41:0] op_mem [`FM_SLOTS];
	logic [41:0] op_out, op_in;
	logic [25:0] ch_mem [`FM_CHANNELS];
	logic [25:0] ch_out, ch_in;

	assign cur_op = cur[4:3];
	assign cur_ch = cur[2:0];
	assign nxt     = cur + 5'd1;
	assign rd_slot = rst ? '0 : nxt;  // Slot 0 is ready when reset lifts
	assign target  = {op, ch};

	assign m1_enters = cur_op == 2'd0;
	assign m2_enters = cur_op == 2'd1;
	assign c1_enters = cur_op == 2'd2;
	assign c2_enters = cur_op == 2'd3;

	assign up_op  = up_dt1 | up_tl | up_ks | up_amsen | up_dt2 | up_d1l;
	assign up_ch  = up_rl | up_kc | up_kf | up_pms;
	assign up_any = up_op | up_ch | up_keyon;

	// Busy from the rising level until the write has landed
	assign busy     = up_any && !done;
	assign op_wr    = busy && up_op && target == cur;
	assign ch_wr    = busy && up_ch && ch == cur_ch;  // Channel bits only
	assign keyon_wr = busy && up_keyon;               // Completes at once

	assign keyon_mask = d_in[6:3];
	assign keyon_ch   = d_in[2:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			cur  <= '0;
			zero <= 1'b0;
			done <= 1'b0;
		end else begin
			cur  <= nxt;
			zero <= nxt == '0;
			if (!up_any)
				done <= 1'b0;  // Decoder released the levels
			else if (op_wr || ch_wr || keyon_wr)
				done <= 1'b1;
		end
	end

	assign {dt1, mul, tl, ks, arate, amsen, rate1, dt2, rate2, d1l, rrate} = op_out;

	// Merge new fields over the stored ones of the current slot
	assign op_in = {
		up_dt1   ? d_in[6:0] : {dt1, mul},
		up_tl    ? d_in[6:0] : tl,
		up_ks    ? d_in[7:6] : ks,
		up_ks    ? d_in[4:0] : arate,
		up_amsen ? d_in[7]   : amsen,
		up_amsen ? d_in[4:0] : rate1,
		up_dt2   ? d_in[7:6] : dt2,
		up_dt2   ? d_in[4:0] : rate2,
		up_d1l   ? d_in[7:4] : d1l,
		up_d1l   ? d_in[3:0] : rrate
	};

	always_ff @(posedge clk) begin
		op_out <= op_mem[rd_slot];  // One slot ahead
		if (op_wr)
			op_mem[cur] <= op_in;
	end

	assign {rl, fb, con, kc, kf, pms, ams} = ch_out;

	assign ch_in = {
		up_rl  ? d_in[7:0] : {rl, fb, con},
		up_kc  ? d_in[6:0] : kc,
		up_kf  ? d_in[7:2] : kf,
		up_pms ? d_in[6:4] : pms,
		up_pms ? d_in[1:0] : ams
	};

	always_ff @(posedge clk) begin
		ch_out <= ch_mem[rd_slot[2:0]];
		if (ch_wr)
			ch_mem[cur_ch] <= ch_in;
	end

	a_busy_bound: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> ##[1:34] !busy);

	a_zero_slot: assert property (@(posedge clk) disable iff (rst)
		zero |-> cur_op == 2'd0 && cur_ch == 3'd0);

endmodule

// ==== logic/fm_regs_top.sv ====
// Top level of the FM parameter store with decoder, register file, key-on and routing
`timescale 1ns/1ps

module fm_regs_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr,
	input  logic              a0,
	input  fm_pkg::reg_data_t din,
	input  logic              csm,
	input  logic              overflow_a,
	output logic              busy,
	output logic              zero,
	output fm_pkg::op_t       cur_op,
	output fm_pkg::ch_t       cur_ch,
	output logic              keyon,
	output logic              mod_m1,
	output logic              mod_m2,
	output logic              mod_c1,
	output fm_pkg::small2_t   rl,
	output fm_pkg::small3_t   fb,
	output fm_pkg::alg_t      con,
	output fm_pkg::kc_t       kc,
	output fm_pkg::kf_t       kf,
	output fm_pkg::small3_t   pms,
	output fm_pkg::small2_t   ams,
	output fm_pkg::small3_t   dt1,
	output fm_pkg::rate4_t    mul,
	output fm_pkg::tl_t       tl,
	output fm_pkg::small2_t   ks,
	output fm_pkg::rate5_t    arate,
	output fm_pkg::rate5_t    rate1,
	output fm_pkg::rate5_t    rate2,
	output fm_pkg::rate4_t    rrate,
	output fm_pkg::small2_t   dt2,
	output fm_pkg::rate4_t    d1l,
	output logic              amsen
);
	import fm_pkg::*;

	logic up_rl, up_kc, up_kf, up_pms, up_dt1, up_tl;
	logic up_ks, up_amsen, up_dt2, up_d1l, up_keyon;
	reg_data_t d_in;
	op_t       op;
	ch_t       ch;
	logic       keyon_wr;
	logic [3:0] keyon_mask;
	ch_t        keyon_ch;
	logic m1_enters, m2_enters, c1_enters, c2_enters;

	fm_write_decode u_decode (
		.clk, .rst, .wr, .a0, .din, .busy,
		.up_rl, .up_kc, .up_kf, .up_pms, .up_dt1, .up_tl,
		.up_ks, .up_amsen, .up_dt2, .up_d1l, .up_keyon,
		.d_in, .op, .ch
	);

	fm_reg_file u_regs (
		.clk, .rst, .d_in, .op, .ch,
		.up_rl, .up_kc, .up_kf, .up_pms, .up_dt1, .up_tl,
		.up_ks, .up_amsen, .up_dt2, .up_d1l, .up_keyon,
		.busy, .cur_op, .cur_ch, .zero, .con,
		.m1_enters, .m2_enters, .c1_enters, .c2_enters,
		.keyon_wr, .keyon_mask, .keyon_ch,
		.rl, .fb, .kc, .kf, .pms, .ams,
		.dt1, .mul, .tl, .ks, .arate, .rate1, .rate2, .rrate,
		.dt2, .d1l, .amsen
	);

	fm_keyon u_keyon (
		.clk, .rst, .cur_op, .cur_ch,
		.keyon_wr, .keyon_mask, .keyon_ch,
		.csm, .overflow_a, .keyon
	);

	fm_algo_route u_route (
		.con,
		.m1_enters, .m2_enters, .c1_enters, .c2_enters,
		.mod_m1, .mod_m2, .mod_c1
	);

endmodule

// ==== logic/fm_write_decode.sv ====
// Host write decoder with address latch, register map decode and pending write hold
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_write_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr,
	input  logic              a0,
	input  fm_pkg::reg_data_t din,
	input  logic              busy,
	output logic              up_rl,
	output logic              up_kc,
	output logic              up_kf,
	output logic              up_pms,
	output logic              up_dt1,
	output logic              up_tl,
	output logic              up_ks,
	output logic              up_amsen,
	output logic              up_dt2,
	output logic              up_d1l,
	output logic              up_keyon,
	output fm_pkg::reg_data_t d_in,
	output fm_pkg::op_t       op,
	output fm_pkg::ch_t       ch
);
	import fm_pkg::*;

	dec_state_t  state;
	reg_addr_t   addr;
	logic [10:0] hit;  // Decoded group of the latched address
	logic [10:0] upd;  // Held update levels
	logic        data_wr;

	assign data_wr = wr && a0 && state == DEC_IDLE;

	// Same bit order as the update level outputs
	assign hit = {
		(addr & `FM_CH_GRP_MASK) == `FM_ADDR_RL,
		(addr & `FM_CH_GRP_MASK) == `FM_ADDR_KC,
		(addr & `FM_CH_GRP_MASK) == `FM_ADDR_KF,
		(addr & `FM_CH_GRP_MASK) == `FM_ADDR_PMS,
		(addr & `FM_OP_GRP_MASK) == `FM_ADDR_DT1,
		(addr & `FM_OP_GRP_MASK) == `FM_ADDR_TL,
		(addr & `FM_OP_GRP_MASK) == `FM_ADDR_KS,
		(addr & `FM_OP_GRP_MASK) == `FM_ADDR_AMSEN,
		(addr & `FM_OP_GRP_MASK) == `FM_ADDR_DT2,
		(addr & `FM_OP_GRP_MASK) == `FM_ADDR_D1L,
		addr == `FM_ADDR_KEYON
	};

	assign {up_rl, up_kc, up_kf, up_pms, up_dt1, up_tl,
		up_ks, up_amsen, up_dt2, up_d1l, up_keyon} = upd;

	always_ff @(posedge clk) begin
		if (rst) begin
			addr <= '0;
		end else if (wr && !a0) begin
			addr <= din;  // Address phase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DEC_IDLE;
			upd   <= '0;
		end else begin
			case (state)
				DEC_IDLE: begin
					if (data_wr && |hit) begin  // Unmapped addresses drop here
						state <= DEC_PENDING;
						upd   <= hit;
					end
				end
				DEC_PENDING: begin
					if (!busy) begin  // Register file finished the write
						state <= DEC_IDLE;
						upd   <= '0;
					end
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	// Data and target stay put while the write is pending
	always_ff @(posedge clk) begin
		if (data_wr) begin
			d_in <= din;
			op   <= addr[4:3];
			ch   <= addr[2:0];
		end
	end

	a_one_level: assert property (@(posedge clk) disable iff (rst)
		$onehot0(upd) && ((state == DEC_PENDING) == (upd != '0)));

endmodule
